//--- include/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Architectural sizes
`define MIPS_REG_COUNT 32
`define MIPS_DATA_WIDTH 32
`define MIPS_REG_ADDR_WIDTH 5

// Trace queue holds 2**depth_log2 records
`define MIPS_TRACE_DEPTH_LOG2 6

`endif

//--- hdl/mips_pkg.sv
`include "mips_settings.svh"

package mips_pkg;

    // ======================================================================
    // Datapath types
    // ======================================================================

    typedef logic [`MIPS_DATA_WIDTH-1:0] word_t;

    // One register write from a retiring instruction
    typedef struct packed {
        logic                            wen;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] addr;
        word_t                           data;
    } rf_w_t;

    // ======================================================================
    // Trace control
    // ======================================================================

    typedef enum logic [1:0] {
        TRACE_IDLE   = 2'd0,
        TRACE_ACTIVE = 2'd1,
        TRACE_DRAIN  = 2'd2
    } trace_state_t;

endpackage

//--- hdl/register_file.sv
`timescale 1ns/10ps

`include "mips_settings.svh"

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  mips_pkg::rf_w_t [1:0]           rfw,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rd_addr_0,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rd_addr_1,
    output mips_pkg::word_t                 rd_data_0,
    output mips_pkg::word_t                 rd_data_1
);

    import mips_pkg::*;

    // r0 has no storage
    word_t regs [1:`MIPS_REG_COUNT-1];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            // Lane 1 is older, so lane 0 is applied last and wins a collision
            if (rfw[1].wen && rfw[1].addr != '0)
            begin
                regs[rfw[1].addr] <= rfw[1].data;
            end
            if (rfw[0].wen && rfw[0].addr != '0)
            begin
                regs[rfw[0].addr] <= rfw[0].data;
            end
        end
    end

    always_comb
    begin
        if (rd_addr_0 == '0)
            rd_data_0 = '0;
        else
            rd_data_0 = regs[rd_addr_0];

        if (rd_addr_1 == '0)
            rd_data_1 = '0;
        else
            rd_data_1 = regs[rd_addr_1];
    end

endmodule

//--- hdl/rfwrite_queue.sv
`timescale 1ns/10ps

`include "mips_settings.svh"

module rfwrite_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::rf_w_t [1:0] rfw,
    input  mips_pkg::word_t [1:0] rt_pc,
    input  logic                  trace_enq,
    output mips_pkg::rf_w_t       rfw_out,
    output mips_pkg::word_t       rt_pc_out,
    output logic                  queue_empty,
    output logic                  overflow
);

    import mips_pkg::*;

    localparam int DEPTH = 1 << `MIPS_TRACE_DEPTH_LOG2;

    rf_w_t rf_mem [DEPTH];
    word_t pc_mem [DEPTH];
    logic [DEPTH-1:0] valid;

    logic [`MIPS_TRACE_DEPTH_LOG2-1:0] head;
    logic [`MIPS_TRACE_DEPTH_LOG2-1:0] tail;
    logic [`MIPS_TRACE_DEPTH_LOG2-1:0] slot_0;
    logic [`MIPS_TRACE_DEPTH_LOG2-1:0] wr_slot_0;

    logic in_1;
    logic in_0;
    logic acc_1;
    logic acc_0;
    logic head_valid;
    logic bypass;
    logic wr_1;
    logic wr_0;

    logic                            out_valid;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] out_addr;
    word_t                           out_data;
    word_t                           out_pc;

    // ======================================================================
    // Admission
    // ======================================================================

    always_comb
    begin
        in_1       = trace_enq && rfw[1].wen;
        in_0       = trace_enq && rfw[0].wen;
        head_valid = valid[head];

        // Lane 1 takes the tail first, lane 0 the slot after it
        acc_1  = in_1 && !valid[tail];
        slot_0 = acc_1 ? tail + 1'b1 : tail;
        acc_0  = in_0 && !valid[slot_0];

        // Empty queue sends the oldest arrival straight to the output
        bypass = !head_valid && (acc_1 || acc_0);

        wr_1      = acc_1 && !bypass;
        wr_0      = acc_0 && !(bypass && !acc_1);
        wr_slot_0 = wr_1 ? tail + 1'b1 : tail;
    end

    // ======================================================================
    // Control state
    // ======================================================================

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            head      <= '0;
            tail      <= '0;
            valid     <= '0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end
        else
        begin
            if (head_valid)
            begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (wr_1)
                valid[tail] <= 1'b1;
            if (wr_0)
                valid[wr_slot_0] <= 1'b1;

            tail <= tail + wr_1 + wr_0;

            out_valid <= head_valid || bypass;

            // Sticky until reset
            if ((in_1 && !acc_1) || (in_0 && !acc_0))
                overflow <= 1'b1;
        end
    end

    // Payload storage and output record
    always_ff @(posedge clk)
    begin
        if (wr_1)
        begin
            rf_mem[tail] <= rfw[1];
            pc_mem[tail] <= rt_pc[1];
        end
        if (wr_0)
        begin
            rf_mem[wr_slot_0] <= rfw[0];
            pc_mem[wr_slot_0] <= rt_pc[0];
        end

        if (head_valid)
        begin
            out_addr <= rf_mem[head].addr;
            out_data <= rf_mem[head].data;
            out_pc   <= pc_mem[head];
        end
        else if (acc_1)
        begin
            out_addr <= rfw[1].addr;
            out_data <= rfw[1].data;
            out_pc   <= rt_pc[1];
        end
        else if (acc_0)
        begin
            out_addr <= rfw[0].addr;
            out_data <= rfw[0].data;
            out_pc   <= rt_pc[0];
        end
    end

    assign rfw_out     = '{wen: out_valid, addr: out_addr, data: out_data};
    assign rt_pc_out   = out_pc;
    assign queue_empty = !head_valid;

endmodule

//--- hdl/trace_ctrl.sv
`timescale 1ns/10ps

module trace_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   trace_start,
    input  logic                   trace_stop,
    input  logic                   queue_empty,
    output logic                   trace_enq,
    output mips_pkg::trace_state_t state
);

    import mips_pkg::*;

    trace_state_t state_next;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            state <= TRACE_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            TRACE_IDLE:
            begin
                if (trace_start)
                    state_next = TRACE_ACTIVE;
            end
            TRACE_ACTIVE:
            begin
                if (trace_stop)
                    state_next = TRACE_DRAIN;
            end
            TRACE_DRAIN:
            begin
                // Start is not honoured until the queue has drained
                if (queue_empty)
                    state_next = TRACE_IDLE;
            end
            default:
            begin
                state_next = TRACE_IDLE;
            end
        endcase
    end

    // Only commits seen while active are traced
    assign trace_enq = (state == TRACE_ACTIVE);

endmodule

//--- hdl/retire_counter.sv
`timescale 1ns/10ps

module retire_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::rf_w_t [1:0] rfw,
    output mips_pkg::word_t       count
);

    logic [1:0] lanes;

    // Number of lanes writing this cycle
    assign lanes = rfw[1].wen + rfw[0].wen;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            count <= '0;
        else
            count <= count + lanes;
    end

endmodule

//--- hdl/commit_trace_top.sv
`timescale 1ns/10ps

`include "mips_settings.svh"

module commit_trace_top (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            commit_wen_0,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] commit_addr_0,
    input  logic [`MIPS_DATA_WIDTH-1:0]     commit_data_0,
    input  logic [`MIPS_DATA_WIDTH-1:0]     commit_pc_0,

    input  logic                            commit_wen_1,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] commit_addr_1,
    input  logic [`MIPS_DATA_WIDTH-1:0]     commit_data_1,
    input  logic [`MIPS_DATA_WIDTH-1:0]     commit_pc_1,

    input  logic                            trace_start,
    input  logic                            trace_stop,

    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rd_addr_0,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rd_addr_1,
    output logic [`MIPS_DATA_WIDTH-1:0]     rd_data_0,
    output logic [`MIPS_DATA_WIDTH-1:0]     rd_data_1,

    output logic                            trace_valid,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] trace_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]     trace_data,
    output logic [`MIPS_DATA_WIDTH-1:0]     trace_pc,
    output logic                            trace_overflow,
    output logic [`MIPS_DATA_WIDTH-1:0]     retire_count,
    output mips_pkg::trace_state_t          trace_state
);

    import mips_pkg::*;

    rf_w_t [1:0] rfw;
    word_t [1:0] rt_pc;
    rf_w_t       rfw_out;
    logic        trace_enq;
    logic        queue_empty;

    // Lane 1 carries the older instruction
    assign rfw[0]   = '{wen: commit_wen_0, addr: commit_addr_0, data: commit_data_0};
    assign rfw[1]   = '{wen: commit_wen_1, addr: commit_addr_1, data: commit_data_1};
    assign rt_pc[0] = commit_pc_0;
    assign rt_pc[1] = commit_pc_1;

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .rfw       (rfw),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

    rfwrite_queue u_rfwrite_queue (
        .clk         (clk),
        .reset       (reset),
        .rfw         (rfw),
        .rt_pc       (rt_pc),
        .trace_enq   (trace_enq),
        .rfw_out     (rfw_out),
        .rt_pc_out   (trace_pc),
        .queue_empty (queue_empty),
        .overflow    (trace_overflow)
    );

    trace_ctrl u_trace_ctrl (
        .clk         (clk),
        .reset       (reset),
        .trace_start (trace_start),
        .trace_stop  (trace_stop),
        .queue_empty (queue_empty),
        .trace_enq   (trace_enq),
        .state       (trace_state)
    );

    retire_counter u_retire_counter (
        .clk   (clk),
        .reset (reset),
        .rfw   (rfw),
        .count (retire_count)
    );

    // Record valid rides in the wen field
    assign trace_valid = rfw_out.wen;
    assign trace_addr  = rfw_out.addr;
    assign trace_data  = rfw_out.data;

endmodule

//--- verification/commit_trace_tb.sv
`timescale 1ns/10ps

`include "mips_settings.svh"

module commit_trace_tb;

    import mips_pkg::*;

    localparam int QUEUE_DEPTH = 1 << `MIPS_TRACE_DEPTH_LOG2;

    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        word_t     pc;
    } trace_rec_t;

    logic         clk;
    logic         reset;
    logic         commit_wen_0;
    reg_addr_t    commit_addr_0;
    word_t        commit_data_0;
    word_t        commit_pc_0;
    logic         commit_wen_1;
    reg_addr_t    commit_addr_1;
    word_t        commit_data_1;
    word_t        commit_pc_1;
    logic         trace_start;
    logic         trace_stop;
    reg_addr_t    rd_addr_0;
    reg_addr_t    rd_addr_1;
    word_t        rd_data_0;
    word_t        rd_data_1;
    logic         trace_valid;
    reg_addr_t    trace_addr;
    word_t        trace_data;
    word_t        trace_pc;
    logic         trace_overflow;
    word_t        retire_count;
    trace_state_t trace_state;

    // Reference model
    word_t        shadow [`MIPS_REG_COUNT];
    trace_rec_t   exp_trace [$];
    int           model_occ;
    logic         model_was_empty;
    logic         model_overflow;
    word_t        model_count;
    trace_state_t model_state;
    int           seen_count;
    word_t        next_pc;

    commit_trace_top uut (
        .clk            (clk),
        .reset          (reset),
        .commit_wen_0   (commit_wen_0),
        .commit_addr_0  (commit_addr_0),
        .commit_data_0  (commit_data_0),
        .commit_pc_0    (commit_pc_0),
        .commit_wen_1   (commit_wen_1),
        .commit_addr_1  (commit_addr_1),
        .commit_data_1  (commit_data_1),
        .commit_pc_1    (commit_pc_1),
        .trace_start    (trace_start),
        .trace_stop     (trace_stop),
        .rd_addr_0      (rd_addr_0),
        .rd_addr_1      (rd_addr_1),
        .rd_data_0      (rd_data_0),
        .rd_data_1      (rd_data_1),
        .trace_valid    (trace_valid),
        .trace_addr     (trace_addr),
        .trace_data     (trace_data),
        .trace_pc       (trace_pc),
        .trace_overflow (trace_overflow),
        .retire_count   (retire_count),
        .trace_state    (trace_state)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic string mismatch_text(input string name, input word_t expected,
                                            input word_t actual);
        return $sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(31, 1));
    endfunction

    // Queue admission, one lane at a time, older lane first
    task automatic model_enqueue(input reg_addr_t addr, input word_t data, input word_t pc);
        trace_rec_t rec;
        if (model_occ < QUEUE_DEPTH)
        begin
            rec.addr = addr;
            rec.data = data;
            rec.pc   = pc;
            exp_trace.push_back(rec);
            model_occ++;
        end
        else
        begin
            model_overflow = 1'b1;
        end
    endtask

    always @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++)
                shadow[i] = '0;
            exp_trace.delete();
            model_occ      = 0;
            model_overflow = 1'b0;
            model_count    = '0;
            model_state    = TRACE_IDLE;
        end
        else
        begin
            model_was_empty = (model_occ == 0);
            if (commit_wen_1 && commit_addr_1 != '0)
                shadow[commit_addr_1] = commit_data_1;
            if (commit_wen_0 && commit_addr_0 != '0)
                shadow[commit_addr_0] = commit_data_0;
            model_count = model_count + word_t'(commit_wen_1) + word_t'(commit_wen_0);
            if (model_state == TRACE_ACTIVE)
            begin
                if (commit_wen_1)
                    model_enqueue(commit_addr_1, commit_data_1, commit_pc_1);
                if (commit_wen_0)
                    model_enqueue(commit_addr_0, commit_data_0, commit_pc_0);
            end
            // One record leaves per edge
            if (model_occ > 0)
                model_occ--;
            case (model_state)
                TRACE_IDLE:   if (trace_start) model_state = TRACE_ACTIVE;
                TRACE_ACTIVE: if (trace_stop) model_state = TRACE_DRAIN;
                TRACE_DRAIN:  if (model_was_empty) model_state = TRACE_IDLE;
                default:      model_state = TRACE_IDLE;
            endcase
        end
    end

    // Trace monitor
    always @(negedge clk)
    begin
        if (reset)
            seen_count = 0;
        else if (trace_valid)
        begin
            assert (seen_count < exp_trace.size())
                else fail_run("Trace record emitted when none was expected");
            if (seen_count < exp_trace.size())
            begin
                assert (trace_addr === exp_trace[seen_count].addr)
                    else fail_run(mismatch_text("trace_addr",
                        word_t'(exp_trace[seen_count].addr), word_t'(trace_addr)));
                assert (trace_data === exp_trace[seen_count].data)
                    else fail_run(mismatch_text("trace_data",
                        exp_trace[seen_count].data, trace_data));
                assert (trace_pc === exp_trace[seen_count].pc)
                    else fail_run(mismatch_text("trace_pc", exp_trace[seen_count].pc, trace_pc));
                seen_count++;
            end
        end
    end

    task automatic clear_inputs();
        commit_wen_0 <= 1'b0;
        commit_wen_1 <= 1'b0;
        trace_start  <= 1'b0;
        trace_stop   <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        clear_inputs();
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        clear_inputs();
        trace_start <= 1'b1;
    endtask

    task automatic pulse_stop();
        @(posedge clk);
        clear_inputs();
        trace_stop <= 1'b1;
    endtask

    // One commit cycle, lane 1 holds the older PC
    task automatic commit_pair(input logic w1, input reg_addr_t a1, input word_t d1,
                               input logic w0, input reg_addr_t a0, input word_t d0);
        @(posedge clk);
        clear_inputs();
        commit_wen_1  <= w1;
        commit_addr_1 <= a1;
        commit_data_1 <= d1;
        commit_pc_1   <= next_pc;
        commit_wen_0  <= w0;
        commit_addr_0 <= a0;
        commit_data_0 <= d0;
        commit_pc_0   <= next_pc + 32'd4;
        next_pc = next_pc + 32'd8;
    endtask

    task automatic commit_random(input logic w1, input logic w0);
        commit_pair(w1, reg_addr_t'($urandom_range(31, 0)), $urandom(),
                    w0, reg_addr_t'($urandom_range(31, 0)), $urandom());
    endtask

    task automatic check_read(input reg_addr_t a0, input reg_addr_t a1);
        @(posedge clk);
        clear_inputs();
        rd_addr_0 <= a0;
        rd_addr_1 <= a1;
        @(negedge clk);
        assert (rd_data_0 === shadow[a0])
            else fail_run(mismatch_text("rd_data_0", shadow[a0], rd_data_0));
        assert (rd_data_1 === shadow[a1])
            else fail_run(mismatch_text("rd_data_1", shadow[a1], rd_data_1));
    endtask

    task automatic check_status();
        @(negedge clk);
        assert (trace_state === model_state)
            else fail_run(mismatch_text("trace_state", word_t'(model_state), word_t'(trace_state)));
        assert (retire_count === model_count)
            else fail_run(mismatch_text("retire_count", model_count, retire_count));
        assert (trace_overflow === model_overflow)
            else fail_run(mismatch_text("trace_overflow", word_t'(model_overflow),
                                        word_t'(trace_overflow)));
    endtask

    task automatic wait_state(input trace_state_t target, input int limit);
        int cycles;
        cycles = 0;
        while (trace_state !== target && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (trace_state === target)
            else fail_run($sformatf("Timeout waiting for trace_state %s", target.name()));
    endtask

    // Record counts are stable at the rising edge once commits have stopped
    task automatic wait_trace_drained(input int limit);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (seen_count < exp_trace.size() && cycles < limit);
        assert (seen_count == exp_trace.size())
            else fail_run("Timeout waiting for queued trace records to come out");
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic test_reset_state();
        @(negedge clk);
        assert (trace_valid === 1'b0)
            else fail_run(mismatch_text("trace_valid", '0, word_t'(trace_valid)));
        assert (trace_overflow === 1'b0)
            else fail_run(mismatch_text("trace_overflow", '0, word_t'(trace_overflow)));
        assert (retire_count === '0)
            else fail_run(mismatch_text("retire_count", '0, retire_count));
        assert (trace_state === TRACE_IDLE)
            else fail_run(mismatch_text("trace_state", '0, word_t'(trace_state)));
        repeat (4)
            check_read(reg_addr_t'($urandom()), reg_addr_t'($urandom()));
    endtask

    task automatic test_register_writes();
        reg_addr_t a;
        reg_addr_t b;
        word_t     d;
        a = rand_reg();
        b = rand_reg();
        commit_pair(1'b0, '0, '0, 1'b1, a, $urandom());
        check_read(a, '0);
        commit_pair(1'b1, b, $urandom(), 1'b0, '0, '0);
        check_read(b, a);
        b = (a == 5'd31) ? 5'd1 : a + 5'd1;
        commit_pair(1'b1, a, $urandom(), 1'b1, b, $urandom());
        check_read(a, b);
        // Same register on both lanes, younger lane 0 wins
        d = $urandom();
        commit_pair(1'b1, a, $urandom(), 1'b1, a, d);
        check_read(a, '0);
        assert (rd_data_0 === d)
            else fail_run(mismatch_text("rd_data_0", d, rd_data_0));
        commit_pair(1'b1, '0, $urandom(), 1'b1, '0, $urandom());
        check_read('0, a);
    endtask

    task automatic test_tracing();
        repeat (3) commit_random(1'b1, 1'b1);
        idle_cycle();
        pulse_start();
        repeat (3) commit_random(1'b1, 1'b1);
        repeat (8) commit_random(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
        idle_cycle();
        wait_trace_drained(50);
        check_status();
    endtask

    task automatic test_stop_drain();
        repeat (10) commit_random(1'b1, 1'b1);
        pulse_stop();
        // Ignored while draining
        pulse_start();
        repeat (3) commit_random(1'b1, 1'b1);
        idle_cycle();
        check_status();
        wait_state(TRACE_IDLE, 100);
        wait_trace_drained(20);
        check_status();
    endtask

    task automatic test_retire_count();
        for (int phase = 0; phase < 3; phase++)
        begin
            if (phase == 1)
                pulse_start();
            if (phase == 2)
                pulse_stop();
            repeat (5) commit_random(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
            idle_cycle();
            check_status();
        end
        wait_state(TRACE_IDLE, 100);
        wait_trace_drained(20);
        check_status();
    endtask

    task automatic test_overflow();
        pulse_start();
        repeat (80) commit_random(1'b1, 1'b1);
        idle_cycle();
        check_status();
        assert (trace_overflow === 1'b1)
            else fail_run("Overflow flag did not rise after a full trace queue");
        pulse_stop();
        idle_cycle();
        wait_state(TRACE_IDLE, 200);
        wait_trace_drained(20);
        check_status();
        assert (trace_overflow === 1'b1)
            else fail_run("Overflow flag cleared before reset");
        apply_reset();
        test_reset_state();
    endtask

    initial
    begin
        void'($urandom(6));
        reset         = 1'b1;
        commit_wen_0  = 1'b0;
        commit_addr_0 = '0;
        commit_data_0 = '0;
        commit_pc_0   = '0;
        commit_wen_1  = 1'b0;
        commit_addr_1 = '0;
        commit_data_1 = '0;
        commit_pc_1   = '0;
        trace_start   = 1'b0;
        trace_stop    = 1'b0;
        rd_addr_0     = '0;
        rd_addr_1     = '0;
        next_pc       = $urandom() & 32'hffff_fff0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_register_writes();
        test_tracing();
        test_stop_drain();
        test_retire_count();
        test_overflow();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hdl/mips_pkg.sv
hdl/register_file.sv
hdl/rfwrite_queue.sv
hdl/trace_ctrl.sv
hdl/retire_counter.sv
hdl/commit_trace_top.sv
verification/commit_trace_tb.sv

//--- Makefile
TOP := commit_trace_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		-f filelist.f --top-module $(TOP) -o $(TOP)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
